/* list.f */
hw/rv_pkg.sv
hw/reg_read_if.sv
hw/regfile.sv
hw/inst_decode.sv
hw/alu.sv
hw/exec_core.sv
verification/clk_gen.sv
verification/tb_exec_core.sv

/* run.sh */
#!/bin/sh
# build and run the execute slice simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_exec_core -f list.f -o sim_exec_core
./obj_dir/sim_exec_core | tee sim.log

if grep -q "^test passed$" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

/* verification/tb_exec_core.sv */
// execute slice testbench
`default_nettype none

module tb_exec_core;

  localparam int N_OP    = 300;
  localparam int N_IMM   = 200;
  localparam int N_X0    = 30;
  localparam int N_CHAIN = 80;
  localparam int N_ILL   = 40;
  localparam int TOTAL_INSTR = 10 + 32 + 62 + N_OP + N_IMM + N_X0 + N_CHAIN + N_ILL + 32 + 10;

  logic          clk;
  logic          rst;
  logic          i_valid;
  rv_pkg::inst_t i_instr;
  rv_pkg::ridx_t i_dbg_idx;
  rv_pkg::word_t o_dbg_data;
  logic          o_wb_valid;
  rv_pkg::ridx_t o_wb_rd;
  rv_pkg::word_t o_wb_data;
  logic          o_illegal;

  rv_pkg::word_t model [32];
  logic          pend_wb;
  logic          pend_ill;
  rv_pkg::ridx_t pend_rd;
  rv_pkg::word_t pend_data;
  int            checks;
  int            errors;
  int            chk_base;
  int            err_base;

  clk_gen u_clk_gen (.o_clk(clk));

  exec_core u_exec_core (
    .clk        (clk),
    .rst        (rst),
    .i_valid    (i_valid),
    .i_instr    (i_instr),
    .i_dbg_idx  (i_dbg_idx),
    .o_dbg_data (o_dbg_data),
    .o_wb_valid (o_wb_valid),
    .o_wb_rd    (o_wb_rd),
    .o_wb_data  (o_wb_data),
    .o_illegal  (o_illegal)
  );

  task automatic check_word(input string name, input rv_pkg::word_t exp, input rv_pkg::word_t got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("FAIL t=%0t %s exp=%h got=%h", $time, name, exp, got);
    end
  endtask

  function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::word_t a, input rv_pkg::word_t b);
    logic [5:0] sh;
    sh = b[5:0];
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return {63'b0, $signed(a) < $signed(b)};
      3'd3: return {63'b0, a < b};
      3'd4: return a ^ b;
      // sign fill done by inverting around a logical shift
      3'd5: return (alt && a[63]) ? ~((~a) >> sh) : a >> sh;
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // rv64i semantics on the model returning legality
  function automatic logic model_exec(input rv_pkg::inst_t ins, output rv_pkg::word_t res);
    logic [2:0]    f3;
    logic [6:0]    f7;
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t imm;
    logic          legal;
    f3 = ins[14:12];
    f7 = ins[31:25];
    a = model[ins[19:15]];
    b = model[ins[24:20]];
    imm = {{52{ins[31]}}, ins[31:20]};
    res = '0;
    legal = 1'b0;
    case (ins[6:0])
      7'h33: begin
        legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
        res = alu_ref(f3, f7[5], a, b);
      end
      7'h13: begin
        if (f3 == 3'd1) begin
          legal = (ins[31:26] == 6'h00);
          res = alu_ref(f3, 1'b0, a, {58'b0, ins[25:20]});
        end else if (f3 == 3'd5) begin
          legal = (ins[31:26] == 6'h00) || (ins[31:26] == 6'h10);
          res = alu_ref(f3, ins[30], a, {58'b0, ins[25:20]});
        end else begin
          legal = 1'b1;
          res = alu_ref(f3, 1'b0, a, imm);
        end
      end
      7'h37: begin
        legal = 1'b1;
        res = {{32{ins[31]}}, ins[31:12], 12'b0};
      end
      default: legal = 1'b0;
    endcase
    return legal;
  endfunction

  function automatic rv_pkg::inst_t rand_op(input rv_pkg::ridx_t rd, input rv_pkg::ridx_t rs1,
                                            input rv_pkg::ridx_t rs2);
    logic [2:0] f3;
    logic       alt;
    f3 = 3'($urandom_range(7, 0));
    alt = ((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom_range(1, 0) == 1);
    return {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic rv_pkg::inst_t rand_imm(input rv_pkg::ridx_t rd, input rv_pkg::ridx_t rs1);
    logic [2:0]  f3;
    logic [11:0] imm;
    f3 = 3'($urandom_range(7, 0));
    imm = 12'($urandom);
    if (f3 == 3'd1) begin
      imm[11:6] = 6'h00;
    end else if (f3 == 3'd5) begin
      imm[11:6] = ($urandom_range(1, 0) == 1) ? 6'h10 : 6'h00;
    end
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic rv_pkg::ridx_t rand_reg();
    return rv_pkg::ridx_t'($urandom_range(31, 0));
  endfunction

  // drives one clock and checks the last writeback and this cycle's debug view
  task automatic cycle(input logic v, input rv_pkg::inst_t ins, input rv_pkg::ridx_t dbg);
    logic          legal;
    rv_pkg::word_t res;
    rv_pkg::word_t exp_dbg;
    rv_pkg::ridx_t rd;
    legal = model_exec(ins, res);
    rd = ins[11:7];
    @(posedge clk);
    i_valid   <= v;
    i_instr   <= ins;
    i_dbg_idx <= dbg;
    @(negedge clk);
    check_word("o_wb_valid", rv_pkg::word_t'(pend_wb), rv_pkg::word_t'(o_wb_valid));
    check_word("o_illegal", rv_pkg::word_t'(pend_ill), rv_pkg::word_t'(o_illegal));
    if (pend_wb) begin
      check_word("o_wb_rd", rv_pkg::word_t'(pend_rd), rv_pkg::word_t'(o_wb_rd));
      check_word("o_wb_data", pend_data, o_wb_data);
    end
    exp_dbg = (v && legal && (rd != 0) && (dbg == rd)) ? res : model[dbg];
    check_word("o_dbg_data", exp_dbg, o_dbg_data);
    pend_wb   = v && legal;
    pend_ill  = v && !legal;
    pend_rd   = rd;
    pend_data = (rd == 0) ? '0 : res;
    if (v && legal && (rd != 0)) begin
      model[rd] = res;
    end
  endtask

  task automatic issue(input rv_pkg::inst_t ins);
    cycle(1'b1, ins, ins[11:7]);
  endtask

  task automatic sweep_regs();
    for (int k = 0; k < 32; k++) begin
      cycle(1'b0, '0, rv_pkg::ridx_t'(k));
    end
  endtask

  task automatic report(input string name);
    cycle(1'b0, '0, '0);
    $display("[%s] checks=%0d errors=%0d", name, checks - chk_base, errors - err_base);
    chk_base = checks;
    err_base = errors;
  endtask

  initial begin
    #((TOTAL_INSTR + 100) * 10);
    $display("watchdog expired before the run finished");
    $display("test failed");
    $finish;
  end

  initial begin
    rv_pkg::inst_t w;
    rv_pkg::ridx_t prev;
    rv_pkg::ridx_t rd;
    void'($urandom(32'h130d_5f0d));
    rst = 1'b1;
    i_valid = 1'b0;
    i_instr = '0;
    i_dbg_idx = '0;
    pend_wb = 1'b0;
    pend_ill = 1'b0;
    pend_rd = '0;
    pend_data = '0;
    checks = 0;
    errors = 0;
    chk_base = 0;
    err_base = 0;
    for (int k = 0; k < 32; k++) begin
      model[k] = '0;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    sweep_regs();
    report("reset");

    // seed every register with lui then addi
    for (int k = 1; k < 32; k++) begin
      issue({20'($urandom), 5'(k), 7'h37});
      issue({12'($urandom), 5'(k), 3'd0, 5'(k), 7'h13});
    end
    for (int n = 0; n < N_OP; n++) begin
      issue(rand_op(rand_reg(), rand_reg(), rand_reg()));
    end
    report("reg-reg");

    for (int n = 0; n < N_IMM; n++) begin
      if ($urandom_range(3, 0) == 0) begin
        issue({20'($urandom), rand_reg(), 7'h37});
      end else begin
        issue(rand_imm(rand_reg(), rand_reg()));
      end
    end
    report("imm-lui");

    // writes to x0 and then x0 as source
    for (int n = 0; n < N_X0; n++) begin
      if (n < 20) begin
        w = ($urandom_range(1, 0) == 1) ? rand_op('0, rand_reg(), rand_reg()) :
                                          rand_imm('0, rand_reg());
      end else begin
        w = ($urandom_range(1, 0) == 1) ? rand_op(rand_reg(), '0, '0) : rand_imm(rand_reg(), '0);
      end
      issue(w);
    end
    report("x0");

    for (int c = 0; c < N_CHAIN / 8; c++) begin
      prev = rv_pkg::ridx_t'($urandom_range(31, 1));
      for (int n = 0; n < 8; n++) begin
        rd = rv_pkg::ridx_t'($urandom_range(31, 1));
        w = ($urandom_range(1, 0) == 1) ? rand_op(rd, prev, rand_reg()) : rand_imm(rd, prev);
        issue(w);
        prev = rd;
      end
    end
    report("chain-bypass");

    for (int n = 0; n < N_ILL; n++) begin
      w = $urandom;
      if (n % 2 == 0) begin
        while ((w[6:0] == 7'h33) || (w[6:0] == 7'h13) || (w[6:0] == 7'h37)) begin
          w = $urandom;
        end
      end else begin
        w[6:0] = 7'h33;
        while ((w[31:25] == 7'h00) ||
               ((w[31:25] == 7'h20) && ((w[14:12] == 3'd0) || (w[14:12] == 3'd5)))) begin
          w[31:25] = 7'($urandom);
        end
      end
      issue(w);
    end
    sweep_regs();
    report("illegal");

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/clk_gen.sv */
// testbench clock source
`default_nettype none

module clk_gen (
  output logic o_clk
);

  // period of 10
  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

/* hw/exec_core.sv */
// single-cycle execute slice
`default_nettype none

module exec_core (
  input  wire                clk,
  input  wire                rst,

  input  wire                i_valid,
  input  wire rv_pkg::inst_t i_instr,

  input  wire rv_pkg::ridx_t i_dbg_idx,
  output rv_pkg::word_t      o_dbg_data,

  output logic               o_wb_valid,
  output rv_pkg::ridx_t      o_wb_rd,
  output rv_pkg::word_t      o_wb_data,
  output logic               o_illegal
);

  rv_pkg::alu_op_t alu_op;
  logic            use_imm;
  rv_pkg::word_t   imm;
  rv_pkg::ridx_t   rd;
  logic            rd_wen;
  logic            illegal;
  logic            wen;
  rv_pkg::word_t   alu_b;
  rv_pkg::word_t   alu_result;

  reg_read_if rd_if ();

  inst_decode u_inst_decode (
    .i_instr   (i_instr),
    .rd_port   (rd_if.requester),
    .o_alu_op  (alu_op),
    .o_use_imm (use_imm),
    .o_imm     (imm),
    .o_rd      (rd),
    .o_rd_wen  (rd_wen),
    .o_illegal (illegal)
  );

  assign wen = i_valid && rd_wen && !illegal;

  regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .rd_port    (rd_if.responder),
    .i_rd       (rd),
    .i_rd_wen   (wen),
    .i_rd_data  (alu_result),
    .i_dbg_idx  (i_dbg_idx),
    .o_dbg_data (o_dbg_data)
  );

  assign alu_b = use_imm ? imm : rd_if.rs2_data;

  alu u_alu (
    .i_op     (alu_op),
    .i_a      (rd_if.rs1_data),
    .i_b      (alu_b),
    .o_result (alu_result)
  );

  // writeback report one cycle after the instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      o_wb_valid <= 1'b0;
      o_illegal  <= 1'b0;
    end else begin
      o_wb_valid <= wen;
      o_illegal  <= i_valid && illegal;
    end
  end

  // x0 reports zero like the register itself
  always_ff @(posedge clk) begin
    if (wen) begin
      o_wb_rd   <= rd;
      o_wb_data <= (rd == '0) ? '0 : alu_result;
    end
  end

endmodule

`default_nettype wire

/* hw/alu.sv */
// 64-bit integer alu
`default_nettype none

module alu (
  input  wire rv_pkg::alu_op_t i_op,
  input  wire rv_pkg::word_t   i_a,
  input  wire rv_pkg::word_t   i_b,
  output rv_pkg::word_t        o_result
);

  logic [rv_pkg::SHAMT_W-1:0] shamt;
  logic                       lt_signed;
  logic                       lt_unsigned;

  // only the low bits of b count for shifts
  assign shamt = i_b[rv_pkg::SHAMT_W-1:0];

  assign lt_signed   = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;

  always_comb begin
    case (i_op)
      rv_pkg::ALU_ADD: begin
        o_result = i_a + i_b;
      end
      rv_pkg::ALU_SUB: begin
        o_result = i_a - i_b;
      end
      rv_pkg::ALU_SLL: begin
        o_result = i_a << shamt;
      end
      rv_pkg::ALU_SLT: begin
        o_result = rv_pkg::word_t'(lt_signed);
      end
      rv_pkg::ALU_SLTU: begin
        o_result = rv_pkg::word_t'(lt_unsigned);
      end
      rv_pkg::ALU_XOR: begin
        o_result = i_a ^ i_b;
      end
      rv_pkg::ALU_SRL: begin
        o_result = i_a >> shamt;
      end
      rv_pkg::ALU_SRA: begin
        // arithmetic shift keeps the sign
        o_result = $unsigned($signed(i_a) >>> shamt);
      end
      rv_pkg::ALU_OR: begin
        o_result = i_a | i_b;
      end
      rv_pkg::ALU_AND: begin
        o_result = i_a & i_b;
      end
      rv_pkg::ALU_PASSB: begin
        o_result = i_b;
      end
      default: begin
        o_result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/inst_decode.sv */
// instruction decoder
`default_nettype none

module inst_decode (
  input  wire rv_pkg::inst_t i_instr,

  reg_read_if.requester      rd_port,

  output rv_pkg::alu_op_t    o_alu_op,
  output logic               o_use_imm,
  output rv_pkg::word_t      o_imm,
  output rv_pkg::ridx_t      o_rd,
  output logic               o_rd_wen,
  output logic               o_illegal
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic          is_shift;
  logic          op_legal;
  logic          shift_legal;
  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_sh;
  rv_pkg::word_t imm_u;

  assign opcode = i_instr[6:0];
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];

  assign o_rd        = i_instr[11:7];
  assign rd_port.rs1 = i_instr[19:15];
  assign rd_port.rs2 = i_instr[24:20];

  assign imm_i  = {{(rv_pkg::XLEN-12){i_instr[31]}}, i_instr[31:20]};
  assign imm_sh = {{(rv_pkg::XLEN-rv_pkg::SHAMT_W){1'b0}}, i_instr[20 +: rv_pkg::SHAMT_W]};
  // lui result is sign extended on rv64
  assign imm_u  = {{(rv_pkg::XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};

  assign is_shift = (funct3 == rv_pkg::F3_SLL) || (funct3 == rv_pkg::F3_SRL_SRA);

  // alt funct7 only exists for sub and sra
  assign op_legal = (funct7 == rv_pkg::F7_BASE) ||
                    ((funct7 == rv_pkg::F7_ALT) &&
                     ((funct3 == rv_pkg::F3_ADD_SUB) || (funct3 == rv_pkg::F3_SRL_SRA)));

  // rv64 shifts keep bit 25 for shamt, so check bits 31:26 only
  assign shift_legal = (i_instr[31:26] == 6'b000000) ||
                       ((i_instr[31:26] == 6'b010000) && (funct3 == rv_pkg::F3_SRL_SRA));

  function automatic rv_pkg::alu_op_t map_op(input logic [2:0] f3, input logic alt);
    case (f3)
      rv_pkg::F3_ADD_SUB: return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      rv_pkg::F3_SLL:     return rv_pkg::ALU_SLL;
      rv_pkg::F3_SLT:     return rv_pkg::ALU_SLT;
      rv_pkg::F3_SLTU:    return rv_pkg::ALU_SLTU;
      rv_pkg::F3_XOR:     return rv_pkg::ALU_XOR;
      rv_pkg::F3_SRL_SRA: return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      rv_pkg::F3_OR:      return rv_pkg::ALU_OR;
      default:            return rv_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    o_alu_op        = rv_pkg::ALU_ADD;
    o_use_imm       = 1'b0;
    o_imm           = imm_i;
    o_rd_wen        = 1'b0;
    o_illegal       = 1'b0;
    rd_port.rs1_ren = 1'b0;
    rd_port.rs2_ren = 1'b0;
    case (opcode)
      rv_pkg::OPC_OP: begin
        rd_port.rs1_ren = 1'b1;
        rd_port.rs2_ren = 1'b1;
        o_alu_op        = map_op(funct3, funct7 == rv_pkg::F7_ALT);
        o_illegal       = !op_legal;
        o_rd_wen        = op_legal;
      end
      rv_pkg::OPC_OP_IMM: begin
        rd_port.rs1_ren = 1'b1;
        o_use_imm       = 1'b1;
        if (is_shift) begin
          o_imm     = imm_sh;
          o_alu_op  = map_op(funct3, i_instr[30]);
          o_illegal = !shift_legal;
          o_rd_wen  = shift_legal;
        end else begin
          o_alu_op = map_op(funct3, 1'b0);
          o_rd_wen = 1'b1;
        end
      end
      rv_pkg::OPC_LUI: begin
        o_alu_op  = rv_pkg::ALU_PASSB;
        o_use_imm = 1'b1;
        o_imm     = imm_u;
        o_rd_wen  = 1'b1;
      end
      default: begin
        o_illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/regfile.sv */
// architectural register file
`default_nettype none

module regfile (
  input  wire                clk,
  input  wire                rst,

  reg_read_if.responder      rd_port,

  input  wire rv_pkg::ridx_t i_rd,
  input  wire                i_rd_wen,
  input  wire rv_pkg::word_t i_rd_data,

  input  wire rv_pkg::ridx_t i_dbg_idx,
  output rv_pkg::word_t      o_dbg_data
);

  rv_pkg::word_t regs [rv_pkg::NREGS];
  logic          wr_hit_dbg;

  // x0 is never written so it stays at its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd != '0)) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  // gated reads give zero when disabled or x0
  assign rd_port.rs1_data = (rd_port.rs1_ren && (rd_port.rs1 != '0)) ?
                            regs[rd_port.rs1] : '0;
  assign rd_port.rs2_data = (rd_port.rs2_ren && (rd_port.rs2 != '0)) ?
                            regs[rd_port.rs2] : '0;

  // debug view sees the write of this cycle
  assign wr_hit_dbg = i_rd_wen && (i_rd != '0) && (i_rd == i_dbg_idx);
  assign o_dbg_data = wr_hit_dbg ? i_rd_data : regs[i_dbg_idx];

endmodule

`default_nettype wire

/* hw/reg_read_if.sv */
// register file read ports
`default_nettype none

interface reg_read_if;

  rv_pkg::ridx_t rs1;
  logic          rs1_ren;
  rv_pkg::word_t rs1_data;

  rv_pkg::ridx_t rs2;
  logic          rs2_ren;
  rv_pkg::word_t rs2_data;

  modport requester (
    output rs1, rs1_ren, rs2, rs2_ren,
    input  rs1_data, rs2_data
  );

  modport responder (
    input  rs1, rs1_ren, rs2, rs2_ren,
    output rs1_data, rs2_data
  );

endinterface

`default_nettype wire

/* hw/rv_pkg.sv */
// rv64i execute slice definitions
`default_nettype none

package rv_pkg;

  localparam int XLEN    = 64;
  localparam int NREGS   = 32;
  localparam int RIDX_W  = $clog2(NREGS);
  localparam int SHAMT_W = $clog2(XLEN);

  typedef logic [RIDX_W-1:0] ridx_t;
  typedef logic [XLEN-1:0]   word_t;
  typedef logic [31:0]       inst_t;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 encodings shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 alt form selects sub and sra
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASSB
  } alu_op_t;

endpackage

`default_nettype wire
